//--- include/cu_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Encodings shared by the control unit and bench.
// Opcode numbering follows the teaching ISA. The dropped
// jr, jal, in, out, mfhi and mflo codes still exist here.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CU_MACROS_SVH
`define CU_MACROS_SVH

// Field widths.
`define INSTR_WIDTH     32
`define OPCODE_MSB      31
`define OPCODE_LSB      27
`define ALU_SEL_WIDTH   5
`define CLASS_WIDTH     4
`define STEP_WIDTH      3

// Opcodes in instr[31:27].
`define OP_LD     5'b00000
`define OP_LDI    5'b00001
`define OP_ST     5'b00010
`define OP_ADD    5'b00011
`define OP_SUB    5'b00100
`define OP_AND    5'b00101
`define OP_OR     5'b00110
`define OP_SHR    5'b00111
`define OP_SHRA   5'b01000
`define OP_SHL    5'b01001
`define OP_ROR    5'b01010
`define OP_ROL    5'b01011
`define OP_ADDI   5'b01100
`define OP_ANDI   5'b01101
`define OP_ORI    5'b01110
`define OP_MUL    5'b01111
`define OP_DIV    5'b10000
`define OP_NEG    5'b10001
`define OP_NOT    5'b10010
`define OP_BR     5'b10011
`define OP_JR     5'b10100
`define OP_JAL    5'b10101
`define OP_IN     5'b10110
`define OP_OUT    5'b10111
`define OP_MFHI   5'b11000
`define OP_MFLO   5'b11001
`define OP_NOP    5'b11010
`define OP_HALT   5'b11011

// Encoded ALU select.
`define ALU_NONE  5'd0
`define ALU_ADD   5'd1
`define ALU_SUB   5'd2
`define ALU_AND   5'd3
`define ALU_OR    5'd4
`define ALU_SHR   5'd5
`define ALU_SHRA  5'd6
`define ALU_SHL   5'd7
`define ALU_ROR   5'd8
`define ALU_ROL   5'd9
`define ALU_ADDI  5'd10
`define ALU_ANDI  5'd11
`define ALU_ORI   5'd12
`define ALU_MUL   5'd13
`define ALU_DIV   5'd14
`define ALU_NEG   5'd15
`define ALU_NOT   5'd16
`define ALU_BR    5'd17

// Instruction classes.
`define CLS_LOAD     4'd0
`define CLS_LOADIMM  4'd1
`define CLS_STORE    4'd2
`define CLS_ALUREG   4'd3
`define CLS_ALUIMM   4'd4
`define CLS_MULDIV   4'd5
`define CLS_UNARY    4'd6
`define CLS_BRANCH   4'd7
`define CLS_NOP      4'd8
`define CLS_HALT     4'd9

// Execute steps run from T3 up to at most T7.
`define STEP_FIRST_EXEC  3'd3
`define STEP_MAX         3'd7

`endif

//--- source/cuPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types for the control unit.
// Widths come from the macros header.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cu_macros.svh"

package cuPkg;

	typedef logic [`INSTR_WIDTH-1:0] instrT;

	typedef logic [`OPCODE_MSB-`OPCODE_LSB:0] opcodeT;

	typedef logic [`ALU_SEL_WIDTH-1:0] aluSelT;

	typedef logic [`CLASS_WIDTH-1:0] instClassT;

	// Execute step number, T3 to T7.
	typedef logic [`STEP_WIDTH-1:0] stepT;

	typedef enum logic [2:0] {
		stFetch0,
		stFetch1,
		stFetch2,
		stExec,
		stHalted
	} seqStateT;

endpackage

//--- source/opcodeDecoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcode decode, purely combinational.
// Dropped and unknown opcodes decode as nop.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cu_macros.svh"

module opcodeDecoder (
	input cuPkg::instrT instr,
	output cuPkg::instClassT instClass,
	output cuPkg::aluSelT aluOp,
	output cuPkg::stepT lastStep
);
	import cuPkg::*;

	opcodeT opcode;

	assign opcode = instr[`OPCODE_MSB:`OPCODE_LSB];

	always_comb begin
		case (opcode)
			`OP_LD: instClass = `CLS_LOAD;
			`OP_LDI: instClass = `CLS_LOADIMM;
			`OP_ST: instClass = `CLS_STORE;
			`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHR, `OP_SHRA, `OP_SHL, `OP_ROR,
			`OP_ROL: instClass = `CLS_ALUREG;
			`OP_ADDI, `OP_ANDI, `OP_ORI: instClass = `CLS_ALUIMM;
			`OP_MUL, `OP_DIV: instClass = `CLS_MULDIV;
			`OP_NEG, `OP_NOT: instClass = `CLS_UNARY;
			`OP_BR: instClass = `CLS_BRANCH;
			`OP_HALT: instClass = `CLS_HALT;
			`OP_JR, `OP_JAL, `OP_IN, `OP_OUT, `OP_MFHI, `OP_MFLO,
			`OP_NOP: instClass = `CLS_NOP;
			default: instClass = `CLS_NOP;
		endcase
	end

	// Address arithmetic for memory ops uses the adder.
	always_comb begin
		case (opcode)
			`OP_LD, `OP_LDI, `OP_ST, `OP_ADD: aluOp = `ALU_ADD;
			`OP_SUB: aluOp = `ALU_SUB;
			`OP_AND: aluOp = `ALU_AND;
			`OP_OR: aluOp = `ALU_OR;
			`OP_SHR: aluOp = `ALU_SHR;
			`OP_SHRA: aluOp = `ALU_SHRA;
			`OP_SHL: aluOp = `ALU_SHL;
			`OP_ROR: aluOp = `ALU_ROR;
			`OP_ROL: aluOp = `ALU_ROL;
			`OP_ADDI: aluOp = `ALU_ADDI;
			`OP_ANDI: aluOp = `ALU_ANDI;
			`OP_ORI: aluOp = `ALU_ORI;
			`OP_MUL: aluOp = `ALU_MUL;
			`OP_DIV: aluOp = `ALU_DIV;
			`OP_NEG: aluOp = `ALU_NEG;
			`OP_NOT: aluOp = `ALU_NOT;
			`OP_BR: aluOp = `ALU_BR;
			default: aluOp = `ALU_NONE;
		endcase
	end

	always_comb begin
		case (instClass)
			`CLS_LOAD, `CLS_STORE: lastStep = `STEP_MAX;
			`CLS_LOADIMM, `CLS_ALUREG, `CLS_ALUIMM: lastStep = 3'd5;
			`CLS_MULDIV, `CLS_BRANCH: lastStep = 3'd6;
			`CLS_UNARY: lastStep = 3'd4;
			default: lastStep = `STEP_FIRST_EXEC;
		endcase
	end

endmodule

//--- source/cuSequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch/execute sequencer, one state per Clock cycle.
// instClass and lastStep are only sampled in stExec,
// after IR has been loaded. Halt holds until arstN.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cu_macros.svh"

module cuSequencer (
	input logic Clock,
	input logic arstN,
	input cuPkg::instClassT instClass,
	input cuPkg::stepT lastStep,
	output cuPkg::seqStateT state,
	output cuPkg::stepT step,
	output logic run
);
	import cuPkg::*;

	seqStateT nextState;
	stepT nextStep;

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= stFetch0;
			step <= `STEP_FIRST_EXEC;
		end else begin
			state <= nextState;
			step <= nextStep;
		end
	end

	always_comb begin
		nextState = stFetch0;
		nextStep = `STEP_FIRST_EXEC;
		case (state)
			stFetch0: nextState = stFetch1;
			stFetch1: nextState = stFetch2;
			// Opcode is not valid yet, so always enter T3.
			stFetch2: nextState = stExec;
			stExec: begin
				if (instClass == `CLS_HALT) begin
					nextState = stHalted;
				end else if (step == lastStep) begin
					nextState = stFetch0;
				end else begin
					nextState = stExec;
					nextStep = step + 1'b1;
				end
			end
			stHalted: nextState = stHalted;
			default: nextState = stFetch0;
		endcase
	end

	assign run = (state != stHalted);

endmodule

//--- source/strobeGenerator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath strobes as full-cycle levels.
// Pure decode of state, step and class; pcIn also
// follows conOut during branch T6.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cu_macros.svh"

module strobeGenerator (
	input cuPkg::seqStateT state,
	input cuPkg::stepT step,
	input cuPkg::instClassT instClass,
	input cuPkg::aluSelT aluOp,
	input logic conOut,
	output cuPkg::aluSelT aluSel,
	output logic gra, grb, grc,
	output logic rIn, rOut, baOut,
	output logic read, write,
	output logic incPc, pcIn, pcOut,
	output logic conIn, irIn, hiIn, loIn,
	output logic zHighIn, zLowIn, marIn, mdrIn, yIn,
	output logic zHighOut, zLowOut, mdrOut, cOut
);
	import cuPkg::*;

	always_comb begin
		{gra, grb, grc, rIn, rOut, baOut, read, write,
			incPc, pcIn, pcOut, conIn, irIn, hiIn, loIn,
			zHighIn, zLowIn, marIn, mdrIn, yIn,
			zHighOut, zLowOut, mdrOut, cOut} = '0;
		aluSel = `ALU_NONE;

		case (state)
			stFetch0: begin
				pcOut = 1'b1;
				marIn = 1'b1;
				incPc = 1'b1;
			end
			stFetch1: begin
				read = 1'b1;
				mdrIn = 1'b1;
			end
			stFetch2: begin
				mdrOut = 1'b1;
				irIn = 1'b1;
			end
			stExec: begin
				case (instClass)
					// Effective address is rb + C for all three.
					`CLS_LOAD, `CLS_LOADIMM, `CLS_STORE: begin
						case (step)
							3'd3: begin
								grb = 1'b1;
								baOut = 1'b1;
								yIn = 1'b1;
							end
							3'd4: begin
								cOut = 1'b1;
								zHighIn = 1'b1;
								zLowIn = 1'b1;
								aluSel = aluOp;
							end
							3'd5: begin
								zLowOut = 1'b1;
								gra = (instClass == `CLS_LOADIMM);
								rIn = (instClass == `CLS_LOADIMM);
								marIn = (instClass != `CLS_LOADIMM);
							end
							3'd6: begin
								mdrIn = 1'b1;
								read = (instClass == `CLS_LOAD);
								gra = (instClass == `CLS_STORE);
								rOut = (instClass == `CLS_STORE);
							end
							3'd7: begin
								mdrOut = 1'b1;
								gra = (instClass == `CLS_LOAD);
								rIn = (instClass == `CLS_LOAD);
								write = (instClass == `CLS_STORE);
							end
							default: ;
						endcase
					end
					`CLS_ALUREG, `CLS_ALUIMM: begin
						case (step)
							3'd3: begin
								grb = 1'b1;
								rOut = 1'b1;
								yIn = 1'b1;
							end
							3'd4: begin
								grc = (instClass == `CLS_ALUREG);
								rOut = (instClass == `CLS_ALUREG);
								cOut = (instClass == `CLS_ALUIMM);
								zHighIn = 1'b1;
								zLowIn = 1'b1;
								aluSel = aluOp;
							end
							3'd5: begin
								zLowOut = 1'b1;
								gra = 1'b1;
								rIn = 1'b1;
							end
							default: ;
						endcase
					end
					`CLS_MULDIV: begin
						case (step)
							3'd3: begin
								gra = 1'b1;
								rOut = 1'b1;
								yIn = 1'b1;
							end
							3'd4: begin
								grb = 1'b1;
								rOut = 1'b1;
								zHighIn = 1'b1;
								zLowIn = 1'b1;
								aluSel = aluOp;
							end
							// LO takes the low half first, HI next cycle.
							3'd5: begin
								zLowOut = 1'b1;
								loIn = 1'b1;
							end
							3'd6: begin
								zHighOut = 1'b1;
								hiIn = 1'b1;
							end
							default: ;
						endcase
					end
					`CLS_UNARY: begin
						case (step)
							3'd3: begin
								grb = 1'b1;
								rOut = 1'b1;
								zHighIn = 1'b1;
								zLowIn = 1'b1;
								aluSel = aluOp;
							end
							3'd4: begin
								gra = 1'b1;
								rIn = 1'b1;
								zLowOut = 1'b1;
							end
							default: ;
						endcase
					end
					`CLS_BRANCH: begin
						case (step)
							3'd3: begin
								gra = 1'b1;
								rOut = 1'b1;
								conIn = 1'b1;
							end
							3'd4: begin
								pcOut = 1'b1;
								yIn = 1'b1;
							end
							3'd5: begin
								cOut = 1'b1;
								zHighIn = 1'b1;
								zLowIn = 1'b1;
								aluSel = aluOp;
							end
							3'd6: begin
								zLowOut = 1'b1;
								pcIn = conOut;
							end
							default: ;
						endcase
					end
					// Nop and halt drive nothing in T3.
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

//--- source/controlUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control unit top. instr must be loaded by the datapath
// on the edge that ends the irIn cycle; no handshake.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module controlUnit (
	input logic Clock,
	input logic arstN,
	input cuPkg::instrT instr,
	input logic conOut,
	output logic run,
	output logic gra, grb, grc,
	output logic rIn, rOut, baOut,
	output logic read, write,
	output logic incPc, pcIn, pcOut,
	output logic conIn, irIn, hiIn, loIn,
	output logic zHighIn, zLowIn, marIn, mdrIn, yIn,
	output logic zHighOut, zLowOut, mdrOut, cOut,
	output cuPkg::aluSelT aluSel
);
	import cuPkg::*;

	instClassT instClass;
	aluSelT aluOp;
	stepT lastStep;
	stepT step;
	seqStateT state;

	opcodeDecoder decoder (
		.instr(instr),
		.instClass(instClass),
		.aluOp(aluOp),
		.lastStep(lastStep)
	);

	cuSequencer sequencer (
		.Clock(Clock),
		.arstN(arstN),
		.instClass(instClass),
		.lastStep(lastStep),
		.state(state),
		.step(step),
		.run(run)
	);

	strobeGenerator strobes (
		.state(state),
		.step(step),
		.instClass(instClass),
		.aluOp(aluOp),
		.conOut(conOut),
		.aluSel(aluSel),
		.gra(gra), .grb(grb), .grc(grc),
		.rIn(rIn), .rOut(rOut), .baOut(baOut),
		.read(read), .write(write),
		.incPc(incPc), .pcIn(pcIn), .pcOut(pcOut),
		.conIn(conIn), .irIn(irIn), .hiIn(hiIn), .loIn(loIn),
		.zHighIn(zHighIn), .zLowIn(zLowIn), .marIn(marIn), .mdrIn(mdrIn), .yIn(yIn),
		.zHighOut(zHighOut), .zLowOut(zLowOut), .mdrOut(mdrOut), .cOut(cOut)
	);

endmodule

//--- bench/strobeChecker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the fetch/execute sequence and the
// strobe table. Outputs are sampled at the falling edge.
// A test ends at the next incPc or when run drops.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cu_macros.svh"

module strobeChecker (
	input logic Clock,
	input logic arstN,
	input logic [`INSTR_WIDTH-1:0] instr,
	input logic conOut,
	input logic [47:0] name,
	input int expCycles,
	input logic run, gra, grb, grc, rIn, rOut, baOut, read, write,
	input logic incPc, pcIn, pcOut, conIn, irIn, hiIn, loIn,
	input logic zHighIn, zLowIn, marIn, mdrIn, yIn,
	input logic zHighOut, zLowOut, mdrOut, cOut,
	input logic [`ALU_SEL_WIDTH-1:0] aluSel,
	output int passCount,
	output int failCount,
	output int pendingErrors,
	output logic sawTaken,
	output logic sawNotTaken
);
	// Bit positions in the strobe vector.
	localparam int bitRun = 24;
	localparam int bitGra = 23;
	localparam int bitGrb = 22;
	localparam int bitGrc = 21;
	localparam int bitRIn = 20;
	localparam int bitROut = 19;
	localparam int bitBaOut = 18;
	localparam int bitRead = 17;
	localparam int bitWrite = 16;
	localparam int bitIncPc = 15;
	localparam int bitPcIn = 14;
	localparam int bitPcOut = 13;
	localparam int bitConIn = 12;
	localparam int bitIrIn = 11;
	localparam int bitHiIn = 10;
	localparam int bitLoIn = 9;
	localparam int bitZhIn = 8;
	localparam int bitZlIn = 7;
	localparam int bitMarIn = 6;
	localparam int bitMdrIn = 5;
	localparam int bitYIn = 4;
	localparam int bitZhOut = 3;
	localparam int bitZlOut = 2;
	localparam int bitMdrOut = 1;
	localparam int bitCOut = 0;

	localparam int kLoad = 0;
	localparam int kLoadImm = 1;
	localparam int kStore = 2;
	localparam int kAluReg = 3;
	localparam int kAluImm = 4;
	localparam int kMulDiv = 5;
	localparam int kUnary = 6;
	localparam int kBranch = 7;
	localparam int kNop = 8;
	localparam int kHalt = 9;

	localparam int phFetch0 = 0;
	localparam int phFetch1 = 1;
	localparam int phFetch2 = 2;
	localparam int phExec = 3;
	localparam int phHalted = 4;

	int mPhase = phFetch0;
	int mStep = 3;
	logic active = 1'b0;
	int cycCount = 0;
	int errs = 0;
	int passes = 0;
	int fails = 0;
	logic takenSeen = 1'b0;
	logic notTakenSeen = 1'b0;
	logic [24:0] expV;
	logic [24:0] actV;
	logic [4:0] expSel;
	logic [4:0] op;

	assign op = instr[`OPCODE_MSB:`OPCODE_LSB];
	assign passCount = passes;
	assign failCount = fails;
	assign pendingErrors = errs;
	assign sawTaken = takenSeen;
	assign sawNotTaken = notTakenSeen;

	function automatic int kindOf(input logic [4:0] opc);
		case (opc)
			`OP_LD: return kLoad;
			`OP_LDI: return kLoadImm;
			`OP_ST: return kStore;
			`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHR, `OP_SHRA, `OP_SHL, `OP_ROR,
			`OP_ROL: return kAluReg;
			`OP_ADDI, `OP_ANDI, `OP_ORI: return kAluImm;
			`OP_MUL, `OP_DIV: return kMulDiv;
			`OP_NEG, `OP_NOT: return kUnary;
			`OP_BR: return kBranch;
			`OP_HALT: return kHalt;
			default: return kNop;
		endcase
	endfunction

	function automatic logic [4:0] selOf(input logic [4:0] opc);
		case (opc)
			`OP_ADD: return `ALU_ADD;
			`OP_SUB: return `ALU_SUB;
			`OP_AND: return `ALU_AND;
			`OP_OR: return `ALU_OR;
			`OP_SHR: return `ALU_SHR;
			`OP_SHRA: return `ALU_SHRA;
			`OP_SHL: return `ALU_SHL;
			`OP_ROR: return `ALU_ROR;
			`OP_ROL: return `ALU_ROL;
			`OP_ADDI: return `ALU_ADDI;
			`OP_ANDI: return `ALU_ANDI;
			`OP_ORI: return `ALU_ORI;
			`OP_MUL: return `ALU_MUL;
			`OP_DIV: return `ALU_DIV;
			`OP_NEG: return `ALU_NEG;
			`OP_NOT: return `ALU_NOT;
			default: return `ALU_NONE;
		endcase
	endfunction

	// Number of execute cycles per kind.
	function automatic int execLen(input int k);
		case (k)
			kLoad, kStore: return 5;
			kLoadImm, kAluReg, kAluImm: return 3;
			kMulDiv, kBranch: return 4;
			kUnary: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic logic [24:0] bitsOf(input int a, input int b, input int c, input int d);
		logic [24:0] v;
		v = '0;
		if (a >= 0) v[a] = 1'b1;
		if (b >= 0) v[b] = 1'b1;
		if (c >= 0) v[c] = 1'b1;
		if (d >= 0) v[d] = 1'b1;
		return v;
	endfunction

	task automatic predict(input int ph, input int stp, input logic [4:0] opc, input logic con,
			output logic [24:0] v, output logic [4:0] sel);
		int k;
		k = kindOf(opc);
		v = bitsOf(bitRun, -1, -1, -1);
		sel = `ALU_NONE;
		case (ph)
			phFetch0: v = v | bitsOf(bitPcOut, bitMarIn, bitIncPc, -1);
			phFetch1: v = v | bitsOf(bitRead, bitMdrIn, -1, -1);
			phFetch2: v = v | bitsOf(bitMdrOut, bitIrIn, -1, -1);
			phExec: begin
				if (k == kLoad || k == kLoadImm || k == kStore) begin
					case (stp)
						3: v = v | bitsOf(bitGrb, bitBaOut, bitYIn, -1);
						4: begin
							v = v | bitsOf(bitCOut, bitZhIn, bitZlIn, -1);
							sel = `ALU_ADD;
						end
						5: v = v | ((k == kLoadImm) ? bitsOf(bitZlOut, bitGra, bitRIn, -1)
							: bitsOf(bitZlOut, bitMarIn, -1, -1));
						6: v = v | ((k == kStore) ? bitsOf(bitGra, bitROut, bitMdrIn, -1)
							: bitsOf(bitRead, bitMdrIn, -1, -1));
						7: v = v | ((k == kStore) ? bitsOf(bitMdrOut, bitWrite, -1, -1)
							: bitsOf(bitMdrOut, bitGra, bitRIn, -1));
						default: ;
					endcase
				end else if (k == kAluReg || k == kAluImm) begin
					case (stp)
						3: v = v | bitsOf(bitGrb, bitROut, bitYIn, -1);
						4: begin
							v = v | ((k == kAluReg) ? bitsOf(bitGrc, bitROut, bitZhIn, bitZlIn)
								: bitsOf(bitCOut, bitZhIn, bitZlIn, -1));
							sel = selOf(opc);
						end
						5: v = v | bitsOf(bitZlOut, bitGra, bitRIn, -1);
						default: ;
					endcase
				end else if (k == kMulDiv) begin
					case (stp)
						3: v = v | bitsOf(bitGra, bitROut, bitYIn, -1);
						4: begin
							v = v | bitsOf(bitGrb, bitROut, bitZhIn, bitZlIn);
							sel = selOf(opc);
						end
						5: v = v | bitsOf(bitZlOut, bitLoIn, -1, -1);
						6: v = v | bitsOf(bitZhOut, bitHiIn, -1, -1);
						default: ;
					endcase
				end else if (k == kUnary) begin
					if (stp == 3) begin
						v = v | bitsOf(bitGrb, bitROut, bitZhIn, bitZlIn);
						sel = selOf(opc);
					end else if (stp == 4) begin
						v = v | bitsOf(bitGra, bitRIn, bitZlOut, -1);
					end
				end else if (k == kBranch) begin
					case (stp)
						3: v = v | bitsOf(bitGra, bitROut, bitConIn, -1);
						4: v = v | bitsOf(bitPcOut, bitYIn, -1, -1);
						5: begin
							v = v | bitsOf(bitCOut, bitZhIn, bitZlIn, -1);
							sel = `ALU_BR;
						end
						// Taken only when the condition holds.
						6: v = v | bitsOf(bitZlOut, con ? bitPcIn : -1, -1, -1);
						default: ;
					endcase
				end
			end
			default: v = '0;
		endcase
	endtask

	task automatic finishTest();
		if (cycCount != expCycles) begin
			$display("** Error %0s: cycle count expected %0d actual %0d", name, expCycles,
				cycCount);
			errs++;
		end
		if (errs == 0) begin
			passes++;
			$display("PASS %0s: %0d cycles", name, cycCount);
		end else begin
			fails++;
			$display("FAIL %0s: %0d mismatches", name, errs);
		end
		errs = 0;
	endtask

	always @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			mPhase <= phFetch0;
			mStep <= 3;
		end else begin
			case (mPhase)
				phFetch0: mPhase <= phFetch1;
				phFetch1: mPhase <= phFetch2;
				phFetch2: begin
					mPhase <= phExec;
					mStep <= 3;
				end
				phExec: begin
					if (kindOf(op) == kHalt) begin
						mPhase <= phHalted;
					end else if (mStep - 2 >= execLen(kindOf(op))) begin
						mPhase <= phFetch0;
					end else begin
						mStep <= mStep + 1;
					end
				end
				default: mPhase <= phHalted;
			endcase
		end
	end

	always @(negedge Clock) begin
		predict(mPhase, mStep, op, conOut, expV, expSel);
		actV = {run, gra, grb, grc, rIn, rOut, baOut, read, write, incPc, pcIn, pcOut,
			conIn, irIn, hiIn, loIn, zHighIn, zLowIn, marIn, mdrIn, yIn,
			zHighOut, zLowOut, mdrOut, cOut};
		if (actV !== expV) begin
			$display("** Error %0s phase %0d step %0d: strobes expected %b actual %b",
				name, mPhase, mStep, expV, actV);
			errs++;
		end
		if (aluSel !== expSel) begin
			$display("** Error %0s phase %0d step %0d: aluSel expected %0d actual %0d",
				name, mPhase, mStep, expSel, aluSel);
			errs++;
		end
		// Both conOut values must reach the branch step 6 check.
		if (arstN && mPhase == phExec && mStep == 6 && kindOf(op) == kBranch) begin
			if (conOut) begin
				takenSeen = 1'b1;
			end else begin
				notTakenSeen = 1'b1;
			end
		end
		if (!arstN) begin
			active = 1'b0;
			cycCount = 0;
		end else if (incPc) begin
			if (active) finishTest();
			active = 1'b1;
			cycCount = 1;
		end else if (!run) begin
			if (active) finishTest();
			active = 1'b0;
		end else if (active) begin
			cycCount++;
		end
	end

endmodule

//--- bench/tbControlUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the control unit, acting as the datapath.
// instr is loaded on the edge that ends the irIn cycle.
// conOut is a fresh xorshift bit every cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cu_macros.svh"

module tbControlUnit;

	localparam int numTests = 30;
	localparam int cycleLimit = 8 * numTests + 20;

	logic Clock = 1'b0;
	logic arstN;
	logic [`INSTR_WIDTH-1:0] instr;
	logic conOut = 1'b0;
	logic run, gra, grb, grc, rIn, rOut, baOut, read, write;
	logic incPc, pcIn, pcOut, conIn, irIn, hiIn, loIn;
	logic zHighIn, zLowIn, marIn, mdrIn, yIn;
	logic zHighOut, zLowOut, mdrOut, cOut;
	logic [`ALU_SEL_WIDTH-1:0] aluSel;

	// Instruction table: name, opcode, expected cycles.
	logic [47:0] tblName [numTests];
	logic [`OPCODE_MSB-`OPCODE_LSB:0] tblOp [numTests];
	int tblCycles [numTests];
	int n;

	logic [47:0] curName;
	int curCycles;
	logic [31:0] rng = 32'd83;
	logic [31:0] fill;
	int cycles;
	int passCount;
	int failCount;
	int pendingErrors;
	logic brTaken;
	logic brNotTaken;

	controlUnit uut (
		.Clock(Clock), .arstN(arstN), .instr(instr), .conOut(conOut),
		.run(run), .gra(gra), .grb(grb), .grc(grc),
		.rIn(rIn), .rOut(rOut), .baOut(baOut), .read(read), .write(write),
		.incPc(incPc), .pcIn(pcIn), .pcOut(pcOut),
		.conIn(conIn), .irIn(irIn), .hiIn(hiIn), .loIn(loIn),
		.zHighIn(zHighIn), .zLowIn(zLowIn), .marIn(marIn), .mdrIn(mdrIn), .yIn(yIn),
		.zHighOut(zHighOut), .zLowOut(zLowOut), .mdrOut(mdrOut), .cOut(cOut),
		.aluSel(aluSel)
	);

	strobeChecker strobeCheck (
		.Clock(Clock), .arstN(arstN), .instr(instr), .conOut(conOut),
		.name(curName), .expCycles(curCycles),
		.run(run), .gra(gra), .grb(grb), .grc(grc),
		.rIn(rIn), .rOut(rOut), .baOut(baOut), .read(read), .write(write),
		.incPc(incPc), .pcIn(pcIn), .pcOut(pcOut),
		.conIn(conIn), .irIn(irIn), .hiIn(hiIn), .loIn(loIn),
		.zHighIn(zHighIn), .zLowIn(zLowIn), .marIn(marIn), .mdrIn(mdrIn), .yIn(yIn),
		.zHighOut(zHighOut), .zLowOut(zLowOut), .mdrOut(mdrOut), .cOut(cOut),
		.aluSel(aluSel),
		.passCount(passCount), .failCount(failCount), .pendingErrors(pendingErrors),
		.sawTaken(brTaken), .sawNotTaken(brNotTaken)
	);

	always begin
		#2;
		Clock = ~Clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	always @(posedge Clock) begin
		#1;
		rng = xorshift(rng);
		conOut = rng[0];
	end

	task automatic addEntry(input logic [47:0] nm, input logic [4:0] op, input int cyc);
		tblName[n] = nm;
		tblOp[n] = op;
		tblCycles[n] = cyc;
		n++;
	endtask

	// Returns 1 ns after the edge that ends stFetch2.
	task automatic waitIrLoad();
		@(negedge Clock);
		while (!irIn) begin
			@(negedge Clock);
		end
		@(posedge Clock);
		#1;
	endtask

	task automatic holdHalt(input logic doReset);
		@(negedge Clock);
		while (run) begin
			@(negedge Clock);
		end
		repeat (3) @(posedge Clock);
		if (doReset) begin
			#1;
			arstN = 1'b0;
			repeat (2) @(posedge Clock);
			#1;
			arstN = 1'b1;
		end
	endtask

	initial begin
		cycles = 0;
		while (cycles <= cycleLimit) begin
			@(posedge Clock);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		arstN = 1'b0;
		instr = {`OP_NOP, 27'd0};
		curName = "reset";
		curCycles = 0;
		n = 0;
		addEntry("ld", `OP_LD, 8);
		addEntry("ldi", `OP_LDI, 6);
		addEntry("st", `OP_ST, 8);
		addEntry("add", `OP_ADD, 6);
		addEntry("sub", `OP_SUB, 6);
		addEntry("and", `OP_AND, 6);
		addEntry("or", `OP_OR, 6);
		addEntry("shr", `OP_SHR, 6);
		addEntry("shra", `OP_SHRA, 6);
		addEntry("shl", `OP_SHL, 6);
		addEntry("ror", `OP_ROR, 6);
		addEntry("rol", `OP_ROL, 6);
		addEntry("addi", `OP_ADDI, 6);
		addEntry("andi", `OP_ANDI, 6);
		addEntry("ori", `OP_ORI, 6);
		addEntry("mul", `OP_MUL, 7);
		addEntry("div", `OP_DIV, 7);
		addEntry("neg", `OP_NEG, 5);
		addEntry("not", `OP_NOT, 5);
		addEntry("br", `OP_BR, 7);
		addEntry("br", `OP_BR, 7);
		addEntry("br", `OP_BR, 7);
		addEntry("br", `OP_BR, 7);
		addEntry("jal", `OP_JAL, 4);
		addEntry("jr", `OP_JR, 4);
		addEntry("nop", `OP_NOP, 4);
		addEntry("halt", `OP_HALT, 4);
		addEntry("add", `OP_ADD, 6);
		addEntry("mfhi", `OP_MFHI, 4);
		addEntry("halt", `OP_HALT, 4);

		repeat (4) @(posedge Clock);
		#1;
		arstN = 1'b1;

		for (int i = 0; i < numTests; i++) begin
			waitIrLoad();
			// Register fields vary per entry.
			fill = i * 32'h9E3779B1;
			instr = {tblOp[i], fill[26:0]};
			curName = tblName[i];
			curCycles = tblCycles[i];
			if (tblOp[i] == `OP_HALT) begin
				holdHalt(i != numTests - 1);
			end
		end

		@(posedge Clock);
		$display("Summary: %0d passed, %0d failed, %0d mismatches outside a test",
			passCount, failCount, pendingErrors);
		if (failCount == 0 && pendingErrors == 0 && passCount == numTests
				&& brTaken && brNotTaken) begin
			$display("TESTBENCH PASSED");
		end else begin
			if (passCount + failCount != numTests) begin
				$display("Only %0d of %0d instructions completed", passCount + failCount,
					numTests);
			end
			if (!brTaken || !brNotTaken) begin
				$display("Branch step 6 did not see conOut both high and low");
			end
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+include
source/cuPkg.sv
source/opcodeDecoder.sv
source/cuSequencer.sv
source/strobeGenerator.sv
source/controlUnit.sv
bench/strobeChecker.sv
bench/tbControlUnit.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the control unit testbench with Verilator and runs it.
# Exits non-zero unless the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing -Wno-fatal --top-module tbControlUnit \
	-f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VtbControlUnit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
